// File: build.f
design/px_pkg.sv
design/px_univib.sv
design/px_state_regs.sv
design/px_delay_select.sv
design/px_strobe_seq.sv
design/px_top.sv
tests/px_tb.sv

// File: tests/px_tb.sv
// P-X state control testbench
// Random and directed enter vectors, set pulses, run and step mode against a cycle model
`default_nettype none

module px_tb import px_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADV_TIMEOUT = 200; // Cycles allowed per advance wait

	typedef enum int {
		P_BOOT, // Released but sequencer not started
		P_KICK, // First advance
		P_S1,   // strob1 running
		P_S2,   // strob2 running
		P_DONE  // Strobes over and advance due or held
	} model_phase_t;

	logic      got;
	logic      clo;
	px_enter_t enter;
	logic      sp0;
	logic      sp1;
	logic      si1;
	logic      laduj;
	logic      mode;
	logic      step;
	px_state_t state;
	logic      as2_sum_at;
	logic      strob1;
	logic      strob2;
	logic      advance;

	// Reference model
	px_state_t    exp_state;
	px_state_t    rst_state;
	model_phase_t m_phase;
	int           m_cnt;      // Strobe cycles done in this phase
	int           m_len;      // strob1 length of this machine cycle
	logic         m_need;     // strob2 wanted this machine cycle
	logic         m_step;     // Step seen since last advance
	int           rst_cycles;

	int err_state;
	int err_as2;
	int err_strobe;
	int err_adv;
	int timeouts;

	px_top dut_i (
		.got        (got),
		.clo        (clo),
		.enter      (enter),
		.sp0        (sp0),
		.sp1        (sp1),
		.si1        (si1),
		.laduj      (laduj),
		.mode       (mode),
		.step       (step),
		.state      (state),
		.as2_sum_at (as2_sum_at),
		.strob1     (strob1),
		.strob2     (strob2),
		.advance    (advance)
	);

	initial begin
		got = 1'b0;
		forever #10 got = ~got; // 20 ns period
	end

	// Group b beats group a beats the short default
	function automatic int strob1_cycles(input px_state_t s, input logic ld);
		logic slow_b;
		logic mid_a;
		slow_b = s.p1 | s.k1 | s.k2 | s.i1 | s.i3;
		mid_a  = s.wamp | s.we | s.p4 | (s.k2 & ld);
		if (slow_b) begin
			return 6;
		end else if (mid_a) begin
			return 5;
		end
		return 4;
	endfunction

	function automatic logic strob2_wanted(input px_state_t s);
		logic c_grp;
		logic d_grp;
		logic e_grp;
		c_grp = s.p5 | s.wr | s.ww | s.wm | s.i2 | s.i4 | s.i5;
		d_grp = s.wz | s.p3 | s.wa;
		e_grp = s.p2 | s.wp | s.wx;
		return c_grp | d_grp | e_grp;
	endfunction

	function automatic logic sum_to_at(input px_state_t s);
		return s.wz | s.p4 | s.we | s.wamp;
	endfunction

	// One to three active states with repeats allowed
	function automatic px_enter_t rand_enter();
		logic [21:0] bits;
		int          n;
		bits = '0;
		n    = $urandom_range(3, 1);
		for (int i = 0; i < n; i++) begin
			bits = bits | (22'b1 << $urandom_range(21, 0));
		end
		return px_enter_t'(bits);
	endfunction

	always @(posedge got) begin : check_cycle
		logic exp_adv;
		logic exp_s1;
		logic exp_s2;
		if (clo) begin
			if (rst_cycles > 0) begin // First edge applies the clear
				assert (state == rst_state) else begin
					err_state++;
					$display("Fail %0t: state %h in reset, expected %h", $time, state, rst_state);
				end
				assert (!strob1 && !strob2 && !advance) else begin
					err_strobe++;
					$display("Fail %0t: strobe or advance high in reset", $time);
				end
			end
			rst_cycles++;
			exp_state = rst_state;
			m_phase   = P_BOOT;
			m_cnt     = 0;
			m_step    = 1'b0;
		end else begin
			exp_adv = 1'b0;
			exp_s1  = 1'b0;
			exp_s2  = 1'b0;
			case (m_phase)
				P_KICK: exp_adv = 1'b1;
				P_S1: begin
					if (m_cnt == 0) begin // New states sampled here
						m_len  = strob1_cycles(exp_state, laduj);
						m_need = strob2_wanted(exp_state);
					end
					exp_s1 = 1'b1;
				end
				P_S2: exp_s2 = 1'b1;
				P_DONE: exp_adv = !mode || m_step; // Step mode holds here
				default: exp_adv = 1'b0;
			endcase

			assert (state == exp_state) else begin
				err_state++;
				$display("Fail %0t: state %h, expected %h", $time, state, exp_state);
			end
			assert (as2_sum_at == sum_to_at(exp_state)) else begin
				err_as2++;
				$display("Fail %0t: as2_sum_at %b, expected %b", $time, as2_sum_at,
					sum_to_at(exp_state));
			end
			assert (strob1 == exp_s1) else begin
				err_strobe++;
				$display("Fail %0t: strob1 %b, expected %b", $time, strob1, exp_s1);
			end
			assert (strob2 == exp_s2) else begin
				err_strobe++;
				$display("Fail %0t: strob2 %b, expected %b", $time, strob2, exp_s2);
			end
			assert (advance == exp_adv) else begin
				err_adv++;
				$display("Fail %0t: advance %b, expected %b", $time, advance, exp_adv);
			end

			// Presets win over the loaded next states
			if (exp_adv) begin
				exp_state = px_state_t'(enter);
			end
			if (sp0) begin
				exp_state.p0 = 1'b1;
			end
			if (sp1) begin
				exp_state.p1 = 1'b1;
			end
			if (si1) begin
				exp_state.i1 = 1'b1;
			end
			m_step = exp_adv ? step : (m_step | step); // Step in advance cycle counts later

			case (m_phase)
				P_BOOT: m_phase = P_KICK;
				P_KICK: begin
					m_phase = P_S1;
					m_cnt   = 0;
				end
				P_S1: begin
					m_cnt++;
					if (m_cnt == m_len) begin
						m_cnt   = 0;
						m_phase = m_need ? P_S2 : P_DONE;
					end
				end
				P_S2: begin
					m_cnt++;
					if (m_cnt == 3) begin // Fixed strob2 length
						m_cnt   = 0;
						m_phase = P_DONE;
					end
				end
				P_DONE: begin
					if (exp_adv) begin
						m_phase = P_S1;
						m_cnt   = 0;
					end
				end
				default: m_phase = P_BOOT;
			endcase
		end
	end

	task automatic finish_run();
		int total;
		total = err_state + err_as2 + err_strobe + err_adv + timeouts;
		$display("Errors: state %0d, as2_sum_at %0d, strobes %0d, advance %0d, timeouts %0d",
			err_state, err_as2, err_strobe, err_adv, timeouts);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// Ends on the edge that closes an advance cycle
	task automatic wait_advance(input int limit);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			@(posedge got);
			seen = advance;
			n++;
		end
		if (!seen) begin
			timeouts++;
			$display("Timeout: no advance within %0d cycles at %0t", limit, $time);
			finish_run();
		end
	endtask

	task automatic run_random(input int n);
		repeat (n) begin
			@(negedge got);
			enter = rand_enter();
			laduj = ($urandom_range(1, 0) == 1);
			wait_advance(ADV_TIMEOUT);
		end
	endtask

	// Each state alone at both laduj levels
	task automatic run_one_hot();
		for (int pass = 0; pass < 2; pass++) begin
			for (int b = 0; b < 22; b++) begin
				@(negedge got);
				enter = px_enter_t'(22'b1 << b);
				laduj = pass[0] ^ b[0];
				wait_advance(ADV_TIMEOUT);
			end
		end
	endtask

	// Set pulses land anywhere including advance edges
	task automatic run_with_sets(input int n);
		int gap;
		repeat (n) begin
			@(negedge got);
			enter = rand_enter();
			laduj = ($urandom_range(1, 0) == 1);
			gap   = $urandom_range(7, 0);
			repeat (gap) @(negedge got);
			sp0 = ($urandom_range(2, 0) == 0);
			sp1 = ($urandom_range(2, 0) == 0);
			si1 = ($urandom_range(2, 0) == 0);
			@(negedge got);
			sp0 = 1'b0;
			sp1 = 1'b0;
			si1 = 1'b0;
			wait_advance(ADV_TIMEOUT);
		end
	endtask

	// Step pulse early during strobes or late while held
	task automatic run_step_mode(input int n);
		int gap;
		@(negedge got);
		mode = 1'b1;
		repeat (n) begin
			@(negedge got);
			enter = rand_enter();
			laduj = ($urandom_range(1, 0) == 1);
			gap   = $urandom_range(30, 0);
			repeat (gap) @(negedge got);
			step = 1'b1; // One-cycle pulse
			@(negedge got);
			step = 1'b0;
			wait_advance(ADV_TIMEOUT);
		end
		@(negedge got);
		mode = 1'b0;
	endtask

	initial begin : stimulus
		void'($urandom(35466));
		clo        = 1'b1;
		enter      = '0;
		sp0        = 1'b0;
		sp1        = 1'b0;
		si1        = 1'b0;
		laduj      = 1'b0;
		mode       = 1'b0;
		step       = 1'b0;
		rst_state  = '0;
		rst_state.p0 = 1'b1; // Start state only
		rst_cycles = 0;
		err_state  = 0;
		err_as2    = 0;
		err_strobe = 0;
		err_adv    = 0;
		timeouts   = 0;
		repeat (16) @(negedge got);
		clo = 1'b0;
		run_random(30);
		run_one_hot();
		run_with_sets(30);
		run_step_mode(16);
		run_random(10); // Back in run mode
		finish_run();
	end

endmodule

`default_nettype wire

// File: design/px_top.sv
// P-X state control top
// State bank, delay decode and strobe sequencer on one clock
`default_nettype none

module px_top import px_pkg::*; (
	input  wire logic      got,        // Machine clock
	input  wire logic      clo,        // General clear
	input  wire px_enter_t enter,      // Enter-state requests
	input  wire logic      sp0,        // Set P0
	input  wire logic      sp1,        // Set P1
	input  wire logic      si1,        // Set I1
	input  wire logic      laduj,      // Load flag
	input  wire logic      mode,       // 1 selects step mode
	input  wire logic      step,       // Step pulse
	output wire px_state_t state,      // Current states
	output wire logic      as2_sum_at, // Arithmetic sum to AT
	output wire logic      strob1,     // First strobe
	output wire logic      strob2,     // Second strobe
	output wire logic      advance     // Next-state load
);

	wire logic [LEN_W-1:0] s1_len;  // strob1 length
	wire logic             s2_need; // strob2 wanted

	px_state_regs u_state (
		.got     (got),
		.clo     (clo),
		.advance (advance),
		.enter   (enter),
		.sp0     (sp0),
		.sp1     (sp1),
		.si1     (si1),
		.state   (state)
	);

	px_delay_select u_delay (
		.state      (state),
		.laduj      (laduj),
		.grp        (),           // Group flags stay inside the decode
		.s1_len     (s1_len),
		.s2_need    (s2_need),
		.as2_sum_at (as2_sum_at)
	);

	px_strobe_seq u_seq (
		.got     (got),
		.clo     (clo),
		.s1_len  (s1_len),
		.s2_need (s2_need),
		.mode    (mode),
		.step    (step),
		.strob1  (strob1),
		.strob2  (strob2),
		.advance (advance)
	);

endmodule

`default_nettype wire

// File: design/px_strobe_seq.sv
// P-X strobe sequencer
// Runs strob1, optional strob2, then advance, free running or per step
`default_nettype none

module px_strobe_seq import px_pkg::*; (
	input  wire logic             got,     // Machine clock
	input  wire logic             clo,     // General clear
	input  wire logic [LEN_W-1:0] s1_len,  // strob1 length from decode
	input  wire logic             s2_need, // strob2 requested
	input  wire logic             mode,    // 1 selects step mode
	input  wire logic             step,    // Step pulse
	output logic                  strob1,  // First timing strobe
	output logic                  strob2,  // Second timing strobe
	output logic                  advance  // Load next states
);

	typedef enum logic [1:0] {
		PH_BOOT, // Out of reset
		PH_KICK, // First advance
		PH_STRB, // Strobes running
		PH_WAIT  // Strobes done, waiting for step
	} phase_t;

	phase_t phase;
	phase_t phase_nxt;

	logic adv_d;    // Advance one cycle late, fires strob1
	logic s1_q_d;   // strob1 delayed
	logic s2_q_d;   // strob2 delayed
	logic s2_lat;   // s2_need held for this machine cycle
	logic step_lat; // Step seen since last advance
	logic s1_fall;
	logic s2_fall;
	logic trig_s2;
	logic done;     // First cycle after the last strobe
	logic go;       // Allowed to advance

	px_univib uni_s1 (
		.got  (got),
		.clo  (clo),
		.trig (adv_d),  // New states stable here
		.len  (s1_len),
		.q    (strob1)
	);

	px_univib uni_s2 (
		.got  (got),
		.clo  (clo),
		.trig (trig_s2),
		.len  (S2_LEN),
		.q    (strob2)
	);

	assign s1_fall = s1_q_d & ~strob1;
	assign s2_fall = s2_q_d & ~strob2;
	assign trig_s2 = s1_fall & s2_lat;           // strob2 straight after strob1
	assign done    = (s1_fall & ~s2_lat) | s2_fall;
	assign go      = ~mode | step_lat;           // Run mode never waits

	always_comb begin
		phase_nxt = phase;
		advance   = 1'b0;
		case (phase)
			PH_BOOT: begin
				phase_nxt = PH_KICK;
			end
			PH_KICK: begin
				advance   = 1'b1; // Opens the first machine cycle
				phase_nxt = PH_STRB;
			end
			PH_STRB: begin
				if (done) begin
					if (go) begin
						advance = 1'b1; // Back to back cycles
					end else begin
						phase_nxt = PH_WAIT;
					end
				end
			end
			PH_WAIT: begin
				if (go) begin
					advance   = 1'b1; // Cycle after the step
					phase_nxt = PH_STRB;
				end
			end
			default: begin
				phase_nxt = PH_BOOT;
			end
		endcase
	end

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			phase    <= PH_BOOT;
			adv_d    <= 1'b0;
			s1_q_d   <= 1'b0;
			s2_q_d   <= 1'b0;
			s2_lat   <= 1'b0;
			step_lat <= 1'b0;
		end else begin
			phase  <= phase_nxt;
			adv_d  <= advance;
			s1_q_d <= strob1;
			s2_q_d <= strob2;
			if (adv_d) begin
				s2_lat <= s2_need; // Sampled with the new states
			end
			step_lat <= step | (step_lat & ~advance); // Consumed by advance
		end
	end

endmodule

`default_nettype wire

// File: design/px_delay_select.sv
// P-X transition delay decode
// Sorts active states into delay groups, picks strobe lengths and as2_sum_at
`default_nettype none

module px_delay_select import px_pkg::*; (
	input  wire px_state_t    state,      // Current states
	input  wire logic         laduj,      // Load flag, stretches K2
	output px_group_t         grp,        // Delay group flags
	output logic [LEN_W-1:0]  s1_len,     // strob1 length in cycles
	output logic              s2_need,    // strob2 wanted this cycle
	output logic              as2_sum_at  // Arithmetic sum to AT
);

	always_comb begin
		grp.grp_a = state.wamp | state.we | state.p4
			| (state.k2 & laduj); // K2 joins only while loading
		grp.grp_b = state.p1 | state.k1 | state.k2
			| state.i1 | state.i3;
		grp.grp_c = state.p5 | state.wr | state.ww | state.wm
			| state.i2 | state.i4 | state.i5;
		grp.grp_d = state.wz | state.p3 | state.wa;
		grp.grp_e = state.p2 | state.wp | state.wx;
	end

	// Longest group decides strob1
	always_comb begin
		if (grp.grp_b) begin
			s1_len = S1_LEN_LONG;
		end else if (grp.grp_a) begin
			s1_len = S1_LEN_MID;
		end else begin
			s1_len = S1_LEN_SHORT; // Default, fast states
		end
	end

	assign s2_need = grp.grp_c | grp.grp_d | grp.grp_e; // Second strobe groups

	assign as2_sum_at = state.wz | state.p4 | state.we | state.wamp; // Adder result path

endmodule

`default_nettype wire

// File: design/px_state_regs.sv
// P-X state register bank
// Loads enter requests on advance, set inputs force P0, P1 and I1
`default_nettype none

module px_state_regs import px_pkg::*; (
	input  wire logic      got,     // Machine clock
	input  wire logic      clo,     // General clear
	input  wire logic      advance, // Load the next states
	input  wire px_enter_t enter,   // Enter-state requests
	input  wire logic      sp0,     // Set P0
	input  wire logic      sp1,     // Set P1
	input  wire logic      si1,     // Set I1
	output px_state_t      state    // Current states
);

	px_state_t state_nxt;

	always_comb begin
		state_nxt = state; // Hold between machine cycles
		if (advance) begin
			state_nxt.k1   = enter.k1;
			state_nxt.wp   = enter.wp;
			state_nxt.k2   = enter.k2;
			state_nxt.wa   = enter.wa;
			state_nxt.we   = enter.we;
			state_nxt.wr   = enter.wr;
			state_nxt.wamp = enter.wamp;
			state_nxt.wz   = enter.wz;
			state_nxt.p0   = enter.p0;
			state_nxt.p1   = enter.p1;
			state_nxt.p2   = enter.p2;
			state_nxt.p3   = enter.p3;
			state_nxt.p4   = enter.p4;
			state_nxt.p5   = enter.p5;
			state_nxt.i1   = enter.i1;
			state_nxt.i2   = enter.i2;
			state_nxt.i3   = enter.i3;
			state_nxt.i4   = enter.i4;
			state_nxt.i5   = enter.i5;
			state_nxt.ww   = enter.ww;
			state_nxt.wm   = enter.wm;
			state_nxt.wx   = enter.wx;
		end
		// Preset lines win over the loaded value
		if (sp0) begin
			state_nxt.p0 = 1'b1; // Start request
		end
		if (sp1) begin
			state_nxt.p1 = 1'b1;
		end
		if (si1) begin
			state_nxt.i1 = 1'b1; // Interrupt entry
		end
	end

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			state <= PX_STATE_RESET; // P0 set, rest clear
		end else begin
			state <= state_nxt;
		end
	end

endmodule

`default_nettype wire

// File: design/px_univib.sv
// Retriggerable one-shot counted in got cycles
// Stands in for a monostable, q lasts len cycles from the trigger
`default_nettype none

module px_univib import px_pkg::*; (
	input  wire logic             got,  // Machine clock
	input  wire logic             clo,  // General clear
	input  wire logic             trig, // Fire or refire
	input  wire logic [LEN_W-1:0] len,  // Pulse length in cycles
	output logic                  q     // Pulse out
);

	logic [LEN_W-1:0] cnt;    // Cycles left after this one
	logic [LEN_W-1:0] cnt_ld; // Count seen this cycle

	// Trigger cycle already counts as the first pulse cycle
	assign cnt_ld = trig ? len : cnt;
	assign q      = (cnt_ld != '0);

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			cnt <= '0;
		end else if (q) begin
			cnt <= cnt_ld - 1'b1; // Count down while running
		end else begin
			cnt <= '0;
		end
	end

endmodule

`default_nettype wire

// File: design/px_pkg.sv
// P-X state control shared definitions
// State bank layout, enter requests, delay groups and strobe lengths
`default_nettype none

package px_pkg;

	localparam int LEN_W = 4; // One-shot counter width

	localparam logic [LEN_W-1:0] S1_LEN_SHORT = 4'd4; // strob1, no slow group
	localparam logic [LEN_W-1:0] S1_LEN_MID   = 4'd5; // strob1, group a
	localparam logic [LEN_W-1:0] S1_LEN_LONG  = 4'd6; // strob1, group b wins
	localparam logic [LEN_W-1:0] S2_LEN       = 4'd3; // strob2, fixed

	// One flag per processor state, K/W group in the top bits
	typedef struct packed {
		logic k1;   // Instruction fetch
		logic wp;   // Group K/W
		logic k2;   // Second fetch word
		logic wa;   // Group K/W
		logic we;   // Group K/W
		logic wr;   // Group K/W
		logic wamp; // W& state
		logic wz;   // Group K/W
		logic p0;   // Start state, set on reset
		logic p1;   // Group P
		logic p2;   // Group P
		logic p3;   // Group P
		logic p4;   // Group P
		logic p5;   // Group P
		logic i1;   // Group I
		logic i2;   // Group I
		logic i3;   // Group I
		logic i4;   // Group I
		logic i5;   // Group I
		logic ww;   // Group W
		logic wm;   // Group W
		logic wx;   // Group W
	} px_state_t;

	// Enter requests, same order as the state bank
	typedef struct packed {
		logic k1;
		logic wp;
		logic k2;
		logic wa;
		logic we;
		logic wr;
		logic wamp;
		logic wz;
		logic p0;
		logic p1;
		logic p2;
		logic p3;
		logic p4;
		logic p5;
		logic i1;
		logic i2;
		logic i3;
		logic i4;
		logic i5;
		logic ww;
		logic wm;
		logic wx;
	} px_enter_t;

	// Delay classes of the active states
	typedef struct packed {
		logic grp_a; // Mid strob1
		logic grp_b; // Long strob1
		logic grp_c; // Needs strob2
		logic grp_d; // Needs strob2
		logic grp_e; // Needs strob2
	} px_group_t;

	localparam px_state_t PX_STATE_RESET = '{p0: 1'b1, default: 1'b0}; // Only P0 up

endpackage

`default_nettype wire
